/* hw/pci_axi_settings.svh */
`ifndef PCI_AXI_SETTINGS_SVH
`define PCI_AXI_SETTINGS_SVH

// Low PCI address bits forwarded to AXI, sets the BAR window size
`define PCI_AXI_TARGET_ADDR_BITS 24

// AD and AXI data width
`define PCI_AXI_DATA_BITS 32

// BASE_HIT bit that selects the bridge
`define PCI_AXI_BAR_INDEX 0

`endif

/* hw/pci_local_pkg.sv */
`include "pci_axi_settings.svh"

package pci_local_pkg;

	// AD word of the core back end
	typedef logic [`PCI_AXI_DATA_BITS-1:0] pci_data_t;

	// Byte enables, active low
	typedef logic [`PCI_AXI_DATA_BITS/8-1:0] pci_cbe_t;

	// One flag per BAR
	typedef logic [7:0] base_hit_t;

	// Target sequencer
	typedef enum logic [2:0] {
		TS_IDLE,
		TS_WR_DATA,
		TS_RD_WAIT,
		TS_RD_DATA,
		TS_ABORT
	} target_state_t;

endpackage

/* hw/axil_pkg.sv */
`include "pci_axi_settings.svh"

package axil_pkg;

	typedef logic [31:0] axil_addr_t;

	typedef logic [`PCI_AXI_DATA_BITS-1:0] axil_data_t;

	typedef logic [`PCI_AXI_DATA_BITS/8-1:0] axil_strb_t;

	// BRESP / RRESP codes
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_EXOKAY = 2'b01,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axil_resp_t;

endpackage

/* hw/pci_irq_ctrl.sv */
`timescale 1ns/10ps

module pci_irq_ctrl
(
	input  logic CLK,
	input  logic arst_n,
	input  logic intr_request,
	input  logic int_disable,
	output logic int_n
);
	logic [1:0] req_sync;

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
			req_sync <= 2'b00;
		else
			req_sync <= {req_sync[0], intr_request};
	end

	// Command register bit masks the request
	assign int_n = !(req_sync[1] && !int_disable);

endmodule

/* hw/axil_master.sv */
`timescale 1ns/10ps

module axil_master
(
	input  logic                 CLK,
	input  logic                 arst_n,

	input  logic                 wr_start,
	input  logic                 rd_start,
	input  axil_pkg::axil_addr_t  req_addr,
	input  axil_pkg::axil_data_t  req_wdata,
	input  axil_pkg::axil_strb_t  req_wstrb,
	output logic                 busy,
	output logic                 done,
	output axil_pkg::axil_data_t  rsp_data,
	output axil_pkg::axil_resp_t  rsp_resp,

	output axil_pkg::axil_addr_t  awaddr,
	output logic                 awvalid,
	input  logic                 awready,
	output axil_pkg::axil_data_t  wdata,
	output axil_pkg::axil_strb_t  wstrb,
	output logic                 wvalid,
	input  logic                 wready,
	input  logic                 bvalid,
	input  logic [1:0]           bresp,
	output logic                 bready,
	output axil_pkg::axil_addr_t  araddr,
	output logic                 arvalid,
	input  logic                 arready,
	input  logic                 rvalid,
	input  axil_pkg::axil_data_t  rdata,
	input  logic [1:0]           rresp,
	output logic                 rready
);
	import axil_pkg::*;

	axil_addr_t addr_q;
	logic wr_act;
	logic aw_pend;
	logic w_pend;

	assign aw_pend = awvalid && !awready;
	assign w_pend = wvalid && !wready;
	assign busy = wr_act || arvalid || rready;

	// One transaction at a time, so both channels share the address
	assign awaddr = addr_q;
	assign araddr = addr_q;

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wr_act <= 1'b0;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			bready <= 1'b0;
			arvalid <= 1'b0;
			rready <= 1'b0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;

			if (wr_start)
			begin
				wr_act <= 1'b1;
				awvalid <= 1'b1;
				wvalid <= 1'b1;
			end
			else
			begin
				if (awvalid && awready)
					awvalid <= 1'b0;
				if (wvalid && wready)
					wvalid <= 1'b0;
			end

			// B accepted once AW and W are both through
			if (wr_act && !bready && !aw_pend && !w_pend)
				bready <= 1'b1;
			if (bready && bvalid)
			begin
				bready <= 1'b0;
				wr_act <= 1'b0;
				done <= 1'b1;
			end

			if (rd_start)
				arvalid <= 1'b1;
			else if (arvalid && arready)
			begin
				arvalid <= 1'b0;
				rready <= 1'b1;
			end
			if (rready && rvalid)
			begin
				rready <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK)
	begin
		if (wr_start || rd_start)
			addr_q <= req_addr;
		if (wr_start)
		begin
			wdata <= req_wdata;
			wstrb <= req_wstrb;
		end
		if (bready && bvalid)
			rsp_resp <= axil_resp_t'(bresp);
		if (rready && rvalid)
		begin
			rsp_data <= rdata;
			rsp_resp <= axil_resp_t'(rresp);
		end
	end

endmodule

/* hw/pci_target.sv */
`timescale 1ns/10ps
`include "pci_axi_settings.svh"

module pci_target #(
	parameter int ADDR_VALID_BITS = `PCI_AXI_TARGET_ADDR_BITS
)
(
	input  logic                    CLK,
	input  logic                    arst_n,

	input  pci_local_pkg::pci_data_t addr,
	input  logic                    addr_vld,
	input  pci_local_pkg::base_hit_t base_hit,
	input  logic                    s_wrdn,
	input  logic                    s_data,
	input  logic                    s_data_vld,
	input  pci_local_pkg::pci_data_t adio_in,
	input  pci_local_pkg::pci_cbe_t  s_cbe,
	output pci_local_pkg::pci_data_t adio_out,
	output logic                    s_ready,
	output logic                    s_term,
	output logic                    s_abort,

	input  logic                    busy,
	input  logic                    done,
	input  axil_pkg::axil_data_t     rsp_data,
	input  axil_pkg::axil_resp_t     rsp_resp,
	output logic                    wr_start,
	output logic                    rd_start,
	output axil_pkg::axil_addr_t     req_addr,
	output axil_pkg::axil_data_t     req_wdata,
	output axil_pkg::axil_strb_t     req_wstrb
);
	import pci_local_pkg::*;
	import axil_pkg::*;

	target_state_t state;
	logic rd_pend;
	logic bar_hit;
	logic wr_ok;
	logic rd_done;
	logic rd_err;

	assign bar_hit = addr_vld && base_hit[`PCI_AXI_BAR_INDEX];

	// Write data accepted only when the write buffer is free
	assign wr_ok = (state == TS_WR_DATA) && s_data && !busy && !wr_start;

	assign s_ready = wr_ok || (state == TS_RD_DATA);
	assign s_term = s_ready;
	assign s_abort = (state == TS_ABORT);

	// Read issue waits for a posted write to drain
	assign rd_start = (state == TS_RD_WAIT) && rd_pend && !busy && !wr_start;

	// A done seen before the read was issued belongs to the posted write
	assign rd_done = (state == TS_RD_WAIT) && !rd_pend && done;
	assign rd_err = (rsp_resp == RESP_SLVERR) || (rsp_resp == RESP_DECERR);

	always_ff @(posedge CLK or negedge arst_n)
	begin
		if (!arst_n)
		begin
			state <= TS_IDLE;
			rd_pend <= 1'b0;
			wr_start <= 1'b0;
		end
		else
		begin
			wr_start <= 1'b0;
			case (state)
				TS_IDLE:
				begin
					if (bar_hit)
					begin
						if (s_wrdn)
						begin
							state <= TS_WR_DATA;
						end
						else
						begin
							state <= TS_RD_WAIT;
							rd_pend <= 1'b1;
						end
					end
				end
				TS_WR_DATA:
				begin
					// Posted, PCI side completes now
					if (s_data_vld)
					begin
						wr_start <= 1'b1;
						state <= TS_IDLE;
					end
				end
				TS_RD_WAIT:
				begin
					if (rd_start)
						rd_pend <= 1'b0;
					if (rd_done)
						state <= rd_err ? TS_ABORT : TS_RD_DATA;
				end
				TS_RD_DATA:
				begin
					if (s_data_vld)
						state <= TS_IDLE;
				end
				TS_ABORT:
				begin
					if (!s_data)
						state <= TS_IDLE;
				end
				default:
				begin
					state <= TS_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLK)
	begin
		// Window the address, word aligned
		if ((state == TS_IDLE) && bar_hit)
			req_addr <= axil_addr_t'({addr[ADDR_VALID_BITS-1:2], 2'b00});
		if ((state == TS_WR_DATA) && s_data_vld)
		begin
			req_wdata <= adio_in;
			req_wstrb <= ~s_cbe;
		end
		if (rd_done)
			adio_out <= rsp_data;
	end

endmodule

/* hw/pci_axi_top.sv */
`timescale 1ns/10ps
`include "pci_axi_settings.svh"

module pci_axi_top #(
	parameter int TARGET_ADDR_BITS = `PCI_AXI_TARGET_ADDR_BITS
)
(
	input  logic                    CLK,
	input  logic                    arst_n,

	// Core back end
	input  pci_local_pkg::pci_data_t addr,
	input  logic                    addr_vld,
	input  pci_local_pkg::base_hit_t base_hit,
	input  logic                    s_wrdn,
	input  logic                    s_data,
	input  logic                    s_data_vld,
	input  pci_local_pkg::pci_data_t adio_in,
	input  pci_local_pkg::pci_cbe_t  s_cbe,
	output pci_local_pkg::pci_data_t adio_out,
	output logic                    s_ready,
	output logic                    s_term,
	output logic                    s_abort,

	// AXI4-Lite master
	output axil_pkg::axil_addr_t     awaddr,
	output logic                    awvalid,
	input  logic                    awready,
	output axil_pkg::axil_data_t     wdata,
	output axil_pkg::axil_strb_t     wstrb,
	output logic                    wvalid,
	input  logic                    wready,
	input  logic                    bvalid,
	input  logic [1:0]              bresp,
	output logic                    bready,
	output axil_pkg::axil_addr_t     araddr,
	output logic                    arvalid,
	input  logic                    arready,
	input  logic                    rvalid,
	input  axil_pkg::axil_data_t     rdata,
	input  logic [1:0]              rresp,
	output logic                    rready,

	// Interrupt
	input  logic                    intr_request,
	input  logic                    int_disable,
	output logic                    int_n
);
	import axil_pkg::*;

	logic wr_start;
	logic rd_start;
	logic busy;
	logic done;
	axil_addr_t req_addr;
	axil_data_t req_wdata;
	axil_strb_t req_wstrb;
	axil_data_t rsp_data;
	axil_resp_t rsp_resp;

	pci_target #(
		.ADDR_VALID_BITS(TARGET_ADDR_BITS)
	)
	pci_target_i
	(
		.CLK(CLK),
		.arst_n(arst_n),
		.addr(addr),
		.addr_vld(addr_vld),
		.base_hit(base_hit),
		.s_wrdn(s_wrdn),
		.s_data(s_data),
		.s_data_vld(s_data_vld),
		.adio_in(adio_in),
		.s_cbe(s_cbe),
		.adio_out(adio_out),
		.s_ready(s_ready),
		.s_term(s_term),
		.s_abort(s_abort),
		.busy(busy),
		.done(done),
		.rsp_data(rsp_data),
		.rsp_resp(rsp_resp),
		.wr_start(wr_start),
		.rd_start(rd_start),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_wstrb(req_wstrb)
	);

	axil_master axil_master_i
	(
		.CLK(CLK),
		.arst_n(arst_n),
		.wr_start(wr_start),
		.rd_start(rd_start),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_wstrb(req_wstrb),
		.busy(busy),
		.done(done),
		.rsp_data(rsp_data),
		.rsp_resp(rsp_resp),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bvalid(bvalid),
		.bresp(bresp),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rvalid(rvalid),
		.rdata(rdata),
		.rresp(rresp),
		.rready(rready)
	);

	pci_irq_ctrl pci_irq_ctrl_i
	(
		.CLK(CLK),
		.arst_n(arst_n),
		.intr_request(intr_request),
		.int_disable(int_disable),
		.int_n(int_n)
	);

endmodule

/* verification/pci_axi_assertions.sv */
`timescale 1ns/10ps

module pci_axi_assertions
(
	input logic                 CLK,
	input logic                 arst_n,
	input axil_pkg::axil_addr_t awaddr,
	input logic                 awvalid,
	input logic                 awready,
	input axil_pkg::axil_data_t wdata,
	input axil_pkg::axil_strb_t wstrb,
	input logic                 wvalid,
	input logic                 wready,
	input logic                 arvalid,
	input logic                 s_ready,
	input logic                 s_abort
);
	// AW payload held while stalled
	aw_stable: assert property (@(posedge CLK) disable iff (!arst_n)
		(awvalid && !awready) |=> (awvalid && $stable(awaddr)))
		else $error("AW channel dropped or changed while stalled");

	w_stable: assert property (@(posedge CLK) disable iff (!arst_n)
		(wvalid && !wready) |=> (wvalid && $stable(wdata) && $stable(wstrb)))
		else $error("W channel dropped or changed while stalled");

	ready_abort: assert property (@(posedge CLK) disable iff (!arst_n)
		!(s_ready && s_abort))
		else $error("s_ready and s_abort high together");

	// One transaction at a time
	ar_aw: assert property (@(posedge CLK) disable iff (!arst_n)
		!(arvalid && awvalid))
		else $error("arvalid and awvalid high together");

endmodule

bind axil_master pci_axi_assertions axil_checks_i
(
	.CLK(CLK),
	.arst_n(arst_n),
	.awaddr(awaddr),
	.awvalid(awvalid),
	.awready(awready),
	.wdata(wdata),
	.wstrb(wstrb),
	.wvalid(wvalid),
	.wready(wready),
	.arvalid(arvalid),
	.s_ready(1'b0),
	.s_abort(1'b0)
);

bind pci_target pci_axi_assertions target_checks_i
(
	.CLK(CLK),
	.arst_n(arst_n),
	.awaddr(32'h0),
	.awvalid(1'b0),
	.awready(1'b0),
	.wdata(32'h0),
	.wstrb(4'h0),
	.wvalid(1'b0),
	.wready(1'b0),
	.arvalid(1'b0),
	.s_ready(s_ready),
	.s_abort(s_abort)
);

/* verification/pci_axi_tb.sv */
`timescale 1ns/10ps
`include "pci_axi_settings.svh"

module pci_axi_tb;
	import pci_local_pkg::*;
	import axil_pkg::*;

	localparam int NUM_TESTS = 6;
	localparam int TEST_CYCLES = 600;
	localparam int BAR_HIT = 1 << `PCI_AXI_BAR_INDEX;

	logic CLK;
	logic arst_n;
	pci_data_t addr;
	logic addr_vld;
	base_hit_t base_hit;
	logic s_wrdn;
	logic s_data;
	logic s_data_vld;
	pci_data_t adio_in;
	pci_cbe_t s_cbe;
	pci_data_t adio_out;
	logic s_ready;
	logic s_term;
	logic s_abort;
	axil_addr_t awaddr;
	logic awvalid;
	logic awready = 1'b0;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic wvalid;
	logic wready = 1'b0;
	logic bvalid = 1'b0;
	logic [1:0] bresp = 2'b00;
	logic bready;
	axil_addr_t araddr;
	logic arvalid;
	logic arready = 1'b0;
	logic rvalid = 1'b0;
	axil_data_t rdata = '0;
	logic [1:0] rresp = 2'b00;
	logic rready;
	logic intr_request;
	logic int_disable;
	logic int_n;

	integer seed = 21853;
	logic rand_delay = 1'b0;

	// Slave memory of 1024 words
	axil_data_t mem [0:1023];
	axil_data_t shadow [0:1023];
	logic aw_have;
	logic w_have;
	logic ar_have;
	axil_addr_t aw_a;
	axil_addr_t ar_a;
	axil_data_t w_d;
	axil_strb_t w_s;
	axil_addr_t last_awaddr;

	pci_axi_top pci_axi_top_i
	(
		.CLK(CLK), .arst_n(arst_n),
		.addr(addr), .addr_vld(addr_vld), .base_hit(base_hit), .s_wrdn(s_wrdn),
		.s_data(s_data), .s_data_vld(s_data_vld), .adio_in(adio_in), .s_cbe(s_cbe),
		.adio_out(adio_out), .s_ready(s_ready), .s_term(s_term), .s_abort(s_abort),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bvalid(bvalid), .bresp(bresp), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rready(rready),
		.intr_request(intr_request), .int_disable(int_disable), .int_n(int_n)
	);

	function automatic axil_data_t fill_word(input logic [9:0] idx);
		fill_word = {6'h2A, idx, 6'h15, idx};
	endfunction

	// Byte lanes enabled where the active-low byte enable is clear
	function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t d,
		input pci_cbe_t cbe);
		axil_data_t res;
		res = old;
		for (int b = 0; b < 4; b++)
			if (!cbe[b])
				res[b*8 +: 8] = d[b*8 +: 8];
		merge_bytes = res;
	endfunction

	function automatic logic roll_ready();
		if (!rand_delay)
			roll_ready = 1'b1;
		else
			roll_ready = (($random(seed) & 3) == 0);
	endfunction

	always @(posedge CLK)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < 1024; i++)
				mem[i] = fill_word(10'(i));
			aw_have = 1'b0;
			w_have = 1'b0;
			ar_have = 1'b0;
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			arready <= 1'b0;
			rvalid <= 1'b0;
		end
		else
		begin
			if (awvalid && awready)
			begin
				aw_have = 1'b1;
				aw_a = awaddr;
				last_awaddr = awaddr;
			end
			if (wvalid && wready)
			begin
				w_have = 1'b1;
				w_d = wdata;
				w_s = wstrb;
			end
			awready <= awvalid && !aw_have && roll_ready();
			wready <= wvalid && !w_have && roll_ready();
			if (bvalid && bready)
				bvalid <= 1'b0;
			else if (aw_have && w_have && !bvalid && roll_ready())
			begin
				if (!aw_a[23])
					mem[aw_a[11:2]] = merge_bytes(mem[aw_a[11:2]], w_d, ~w_s);
				bresp <= aw_a[23] ? 2'b10 : 2'b00;
				bvalid <= 1'b1;
				aw_have = 1'b0;
				w_have = 1'b0;
			end
			if (arvalid && arready)
			begin
				ar_have = 1'b1;
				ar_a = araddr;
			end
			arready <= arvalid && !ar_have && roll_ready();
			if (rvalid && rready)
				rvalid <= 1'b0;
			else if (ar_have && !rvalid && roll_ready())
			begin
				rdata <= mem[ar_a[11:2]];
				rresp <= ar_a[23] ? 2'b10 : 2'b00;
				rvalid <= 1'b1;
				ar_have = 1'b0;
			end
		end
	end

	initial
	begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	initial
	begin
		#((16 + NUM_TESTS * TEST_CYCLES) * 100);
		$display("Timeout: the DUT stopped responding and the run was ended");
		$display("TEST FAILED");
		$fatal(1);
	end

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	// Core back end with one address phase and one data phase
	task automatic pci_transfer(input logic wr, input pci_data_t a, input pci_data_t d,
		input pci_cbe_t cbe, output pci_data_t rd, output logic got_ready,
		output logic got_term, output logic got_abort);
		@(posedge CLK);
		addr <= a;
		addr_vld <= 1'b1;
		base_hit <= base_hit_t'(BAR_HIT);
		s_wrdn <= wr;
		@(posedge CLK);
		addr_vld <= 1'b0;
		s_data <= 1'b1;
		adio_in <= d;
		s_cbe <= cbe;
		@(negedge CLK);
		while (!s_ready && !s_abort)
			@(negedge CLK);
		got_ready = s_ready;
		got_term = s_term;
		got_abort = s_abort;
		rd = adio_out;
		@(posedge CLK);
		if (got_ready)
		begin
			s_data_vld <= 1'b1;
			@(posedge CLK);
			s_data_vld <= 1'b0;
		end
		s_data <= 1'b0;
	endtask

	task automatic write_word(input pci_data_t a, input pci_data_t d, input pci_cbe_t cbe);
		pci_data_t rd;
		logic rdy;
		logic trm;
		logic abt;
		pci_transfer(1'b1, a, d, cbe, rd, rdy, trm, abt);
		check("write s_ready", 32'(rdy), 32'd1);
		shadow[a[11:2]] = merge_bytes(shadow[a[11:2]], d, cbe);
	endtask

	task automatic read_word(input pci_data_t a, input pci_data_t exp);
		pci_data_t rd;
		logic rdy;
		logic trm;
		logic abt;
		pci_transfer(1'b0, a, 32'h0, 4'h0, rd, rdy, trm, abt);
		check("read s_ready", 32'(rdy), 32'd1);
		check("read s_term", 32'(trm), 32'd1);
		check("read data", rd, exp);
	endtask

	task automatic test_byte_write();
		write_word(32'hFF00_0105, 32'hDEAD_BEEF, 4'b0101);
		read_word(32'h0000_0104, shadow[10'h41]);
		check("write address", last_awaddr, 32'h0000_0104);
		check("model word", mem[10'h41], shadow[10'h41]);
	endtask

	task automatic test_read();
		read_word(32'h0000_0230, shadow[10'h8C]);
	endtask

	task automatic test_read_error();
		pci_data_t rd;
		logic rdy;
		logic trm;
		logic abt;
		pci_transfer(1'b0, 32'h0080_0010, 32'h0, 4'h0, rd, rdy, trm, abt);
		check("error s_abort", 32'(abt), 32'd1);
		check("error s_ready", 32'(rdy), 32'd0);
	endtask

	task automatic test_no_hit();
		@(posedge CLK);
		addr <= 32'h0000_0040;
		addr_vld <= 1'b1;
		base_hit <= base_hit_t'(BAR_HIT) ^ 8'hFF;
		s_wrdn <= 1'b0;
		@(posedge CLK);
		addr_vld <= 1'b0;
		s_data <= 1'b1;
		repeat (20)
		begin
			@(negedge CLK);
			check("no hit activity", 32'(awvalid | arvalid | s_ready | s_abort), 32'd0);
		end
		@(posedge CLK);
		s_data <= 1'b0;
	endtask

	task automatic test_random_traffic();
		logic [9:0] idx [0:7];
		pci_data_t d;
		rand_delay = 1'b1;
		for (int i = 0; i < 8; i++)
		begin
			idx[i] = 10'($random(seed));
			d = $random(seed);
			write_word({8'($random(seed)), 12'h000, idx[i], 2'b11}, d, 4'($random(seed)));
		end
		for (int i = 0; i < 8; i++)
			read_word({22'h0, idx[i]} << 2, shadow[idx[i]]);
		rand_delay = 1'b0;
	endtask

	task automatic test_irq();
		@(posedge CLK);
		intr_request <= 1'b1;
		@(negedge CLK);
		check("int_n after 0 cycles", 32'(int_n), 32'd1);
		@(negedge CLK);
		check("int_n after 1 cycle", 32'(int_n), 32'd1);
		@(negedge CLK);
		check("int_n after 2 cycles", 32'(int_n), 32'd0);
		@(posedge CLK);
		int_disable <= 1'b1;
		repeat (5)
		begin
			@(negedge CLK);
			check("int_n disabled", 32'(int_n), 32'd1);
		end
		@(posedge CLK);
		intr_request <= 1'b0;
		int_disable <= 1'b0;
	endtask

	initial
	begin
		arst_n = 1'b0;
		addr = '0;
		addr_vld = 1'b0;
		base_hit = '0;
		s_wrdn = 1'b0;
		s_data = 1'b0;
		s_data_vld = 1'b0;
		adio_in = '0;
		s_cbe = '0;
		intr_request = 1'b0;
		int_disable = 1'b0;
		for (int i = 0; i < 1024; i++)
			shadow[i] = fill_word(10'(i));
		repeat (16) @(posedge CLK);
		arst_n <= 1'b1;
		@(negedge CLK);
		check("reset int_n", 32'(int_n), 32'd1);
		check("reset valids", 32'(awvalid | wvalid | arvalid | s_ready | s_abort), 32'd0);
		test_byte_write();
		test_read();
		test_read_error();
		test_no_hit();
		test_random_traffic();
		test_irq();
		$display("TEST PASSED");
		$finish;
	end

endmodule

/* pci_axi_top.f */
+incdir+hw
hw/pci_local_pkg.sv
hw/axil_pkg.sv
hw/pci_irq_ctrl.sv
hw/axil_master.sv
hw/pci_target.sv
hw/pci_axi_top.sv
verification/pci_axi_assertions.sv
verification/pci_axi_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator, result taken from sim.log
rm -f sim.log
verilator --binary --timing --assert -f pci_axi_top.f --top-module pci_axi_tb \
	-o sim_pci_axi > build.log 2>&1 && ./obj_dir/sim_pci_axi > sim.log 2>&1 || true
grep -q "TEST PASSED" sim.log && echo "Simulation passed" && exit 0 || \
	{ echo "Simulation failed, see build.log and sim.log"; exit 1; }
